// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cnn_pool
FILELIST  ?= cnn_pool.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: cnn_pool.f
hdl/cnn_geom_pkg.sv
hdl/wb_bus_pkg.sv
hdl/image_loader.sv
hdl/window_scanner.sv
hdl/conv_mac.sv
hdl/relu_pool.sv
hdl/result_writer.sv
hdl/cnn_pool.sv
verification/cnn_pool_sva.sv
verification/tb_cnn_pool.sv

// File: hdl/cnn_geom_pkg.sv
package cnn_geom_pkg;

    // default side of the square input image
    parameter int DEF_IMG_DIM = 8;

    // 3x3 kernel
    parameter int KERNEL_TAPS = 9;

    typedef logic        [7:0]  pixel_t;
    typedef logic signed [7:0]  weight_t;

    // nine products of 8x8 bits plus sign
    typedef logic signed [19:0] acc_t;

    typedef logic        [15:0] result_t;
    typedef logic        [3:0]  tap_idx_t;

endpackage

// File: hdl/cnn_pool.sv
`timescale 1ns/1ps

module cnn_pool
    import cnn_geom_pkg::*, wb_bus_pkg::*;
#(
    parameter int IMG_DIM = DEF_IMG_DIM
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     i_start,
    input  wb_addr_t i_src_base,
    input  wb_addr_t i_dst_base,
    input  wb_data_t i_rd_dat,
    input  logic     i_rd_ack,
    input  logic     i_wr_ack,
    output logic     o_rd_cyc,
    output logic     o_rd_stb,
    output wb_addr_t o_rd_adr,
    output logic     o_wr_cyc,
    output logic     o_wr_stb,
    output logic     o_wr_we,
    output wb_addr_t o_wr_adr,
    output wb_data_t o_wr_dat,
    output logic     o_busy,
    output logic     o_done
);

    localparam int AW = $clog2(IMG_DIM * IMG_DIM);

    logic          load_done;
    logic [AW-1:0] buf_addr;
    pixel_t        buf_pixel;
    weight_t       weights [KERNEL_TAPS];
    logic          tap_valid;
    pixel_t        tap_pixel;
    tap_idx_t      tap_idx;
    logic          tap_last;
    logic          tap_pool_last;
    logic          sum_valid;
    acc_t          sum;
    logic          sum_pool_last;
    logic          res_valid;
    result_t       res;
    logic          queue_empty;

    image_loader #(.IMG_DIM(IMG_DIM)) u_loader (
        .clk         (clk),
        .reset       (reset),
        .i_start     (i_start),
        .i_src_base  (i_src_base),
        .i_rd_dat    (i_rd_dat),
        .i_rd_ack    (i_rd_ack),
        .i_buf_addr  (buf_addr),
        .i_job_done  (o_done),
        .o_rd_cyc    (o_rd_cyc),
        .o_rd_stb    (o_rd_stb),
        .o_rd_adr    (o_rd_adr),
        .o_busy      (o_busy),
        .o_load_done (load_done),
        .o_weights   (weights),
        .o_buf_pixel (buf_pixel)
    );

    window_scanner #(.IMG_DIM(IMG_DIM)) u_scanner (
        .clk             (clk),
        .reset           (reset),
        .i_load_done     (load_done),
        .i_buf_pixel     (buf_pixel),
        .i_queue_empty   (queue_empty),
        .o_buf_addr      (buf_addr),
        .o_tap_valid     (tap_valid),
        .o_tap_pixel     (tap_pixel),
        .o_tap_idx       (tap_idx),
        .o_tap_last      (tap_last),
        .o_tap_pool_last (tap_pool_last)
    );

    conv_mac u_mac (
        .clk             (clk),
        .reset           (reset),
        .i_weights       (weights),
        .i_tap_valid     (tap_valid),
        .i_tap_pixel     (tap_pixel),
        .i_tap_idx       (tap_idx),
        .i_tap_last      (tap_last),
        .i_tap_pool_last (tap_pool_last),
        .o_sum_valid     (sum_valid),
        .o_sum           (sum),
        .o_sum_pool_last (sum_pool_last)
    );

    relu_pool u_pool (
        .clk             (clk),
        .reset           (reset),
        .i_sum_valid     (sum_valid),
        .i_sum           (sum),
        .i_sum_pool_last (sum_pool_last),
        .o_res_valid     (res_valid),
        .o_res           (res)
    );

    result_writer #(.IMG_DIM(IMG_DIM)) u_writer (
        .clk           (clk),
        .reset         (reset),
        .i_start       (i_start),
        .i_dst_base    (i_dst_base),
        .i_res_valid   (res_valid),
        .i_res         (res),
        .i_wr_ack      (i_wr_ack),
        .o_wr_cyc      (o_wr_cyc),
        .o_wr_stb      (o_wr_stb),
        .o_wr_we       (o_wr_we),
        .o_wr_adr      (o_wr_adr),
        .o_wr_dat      (o_wr_dat),
        .o_queue_empty (queue_empty),
        .o_job_done    (o_done)
    );

endmodule

// File: hdl/conv_mac.sv
`timescale 1ns/1ps

module conv_mac
    import cnn_geom_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  weight_t  i_weights [KERNEL_TAPS],
    input  logic     i_tap_valid,
    input  pixel_t   i_tap_pixel,
    input  tap_idx_t i_tap_idx,
    input  logic     i_tap_last,
    input  logic     i_tap_pool_last,
    output logic     o_sum_valid,
    output acc_t     o_sum,
    output logic     o_sum_pool_last
);

    acc_t product;
    logic first;

    // pixel zero-extended, weight sign-extended
    assign product = acc_t'(i_weights[i_tap_idx]) * acc_t'({1'b0, i_tap_pixel});

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            first           <= 1'b1;
            o_sum_valid     <= 1'b0;
            o_sum_pool_last <= 1'b0;
        end
        else
        begin
            o_sum_valid     <= i_tap_valid && i_tap_last;
            o_sum_pool_last <= i_tap_valid && i_tap_last && i_tap_pool_last;
            if (i_tap_valid)
            begin
                first <= i_tap_last;
            end
        end
    end

    // accumulator restarts on the tap after a ninth tap
    always_ff @(posedge clk)
    begin
        if (i_tap_valid)
        begin
            o_sum <= first ? product : o_sum + product;
        end
    end

endmodule

// File: hdl/image_loader.sv
`timescale 1ns/1ps

module image_loader
    import cnn_geom_pkg::*, wb_bus_pkg::*;
#(
    parameter int IMG_DIM = DEF_IMG_DIM
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               i_start,
    input  wb_addr_t                           i_src_base,
    input  wb_data_t                           i_rd_dat,
    input  logic                               i_rd_ack,
    input  logic [$clog2(IMG_DIM*IMG_DIM)-1:0] i_buf_addr,
    input  logic                               i_job_done,
    output logic                               o_rd_cyc,
    output logic                               o_rd_stb,
    output wb_addr_t                           o_rd_adr,
    output logic                               o_busy,
    output logic                               o_load_done,
    output weight_t                            o_weights [KERNEL_TAPS],
    output pixel_t                             o_buf_pixel
);

    localparam int NPIX = IMG_DIM * IMG_DIM;
    localparam int AW   = $clog2(NPIX);
    localparam int NRD  = KERNEL_TAPS + NPIX;
    localparam int CW   = $clog2(NRD);

    logic          rd_req;
    logic          rd_take;
    logic          rd_last;
    logic          job_go;
    logic [CW-1:0] rd_cnt;
    logic [AW-1:0] pix_addr;
    pixel_t        pix_mem [NPIX];

    assign o_rd_cyc = rd_req;
    assign o_rd_stb = rd_req;
    assign rd_take  = rd_req && i_rd_ack;
    assign rd_last  = (rd_cnt == CW'(NRD - 1));
    assign job_go   = i_start && !o_busy;

    // image words follow the nine weights
    assign pix_addr = AW'(rd_cnt - CW'(KERNEL_TAPS));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_busy      <= 1'b0;
            rd_req      <= 1'b0;
            rd_cnt      <= '0;
            o_load_done <= 1'b0;
        end
        else
        begin
            o_load_done <= rd_take && rd_last;
            if (job_go)
            begin
                o_busy <= 1'b1;
                rd_req <= 1'b1;
                rd_cnt <= '0;
            end
            else if (i_job_done)
            begin
                o_busy <= 1'b0;
            end
            if (rd_take)
            begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_last)
                begin
                    rd_req <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (job_go)
        begin
            o_rd_adr <= i_src_base;
        end
        else if (rd_take)
        begin
            o_rd_adr <= o_rd_adr + 1'b1;
        end
    end

    // only the low byte of each word is kept
    always_ff @(posedge clk)
    begin
        if (rd_take)
        begin
            if (rd_cnt < CW'(KERNEL_TAPS))
            begin
                o_weights[tap_idx_t'(rd_cnt)] <= weight_t'(i_rd_dat[7:0]);
            end
            else
            begin
                pix_mem[pix_addr] <= i_rd_dat[7:0];
            end
        end
        o_buf_pixel <= pix_mem[i_buf_addr];
    end

endmodule

// File: hdl/relu_pool.sv
`timescale 1ns/1ps

module relu_pool
    import cnn_geom_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    i_sum_valid,
    input  acc_t    i_sum,
    input  logic    i_sum_pool_last,
    output logic    o_res_valid,
    output result_t o_res
);

    // magnitude bits of a non-negative sum
    localparam int MW = $bits(acc_t) - 1;
    localparam int RW = $bits(result_t);

    logic [MW-1:0] relu;
    logic [MW-1:0] run_max;
    logic [MW-1:0] blk_max;
    logic          first;

    assign relu    = i_sum[MW] ? '0 : i_sum[MW-1:0];
    assign blk_max = (first || (relu > run_max)) ? relu : run_max;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            first       <= 1'b1;
            o_res_valid <= 1'b0;
        end
        else
        begin
            o_res_valid <= i_sum_valid && i_sum_pool_last;
            if (i_sum_valid)
            begin
                first <= i_sum_pool_last;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_sum_valid)
        begin
            run_max <= blk_max;
        end
        if (i_sum_valid && i_sum_pool_last)
        begin
            // saturate to the 16 bit output range
            o_res <= (|blk_max[MW-1:RW]) ? '1 : blk_max[RW-1:0];
        end
    end

endmodule

// File: hdl/result_writer.sv
`timescale 1ns/1ps

module result_writer
    import cnn_geom_pkg::*, wb_bus_pkg::*;
#(
    parameter int IMG_DIM = DEF_IMG_DIM
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     i_start,
    input  wb_addr_t i_dst_base,
    input  logic     i_res_valid,
    input  result_t  i_res,
    input  logic     i_wr_ack,
    output logic     o_wr_cyc,
    output logic     o_wr_stb,
    output logic     o_wr_we,
    output wb_addr_t o_wr_adr,
    output wb_data_t o_wr_dat,
    output logic     o_queue_empty,
    output logic     o_job_done
);

    localparam int NOUT = (IMG_DIM / 2) * (IMG_DIM / 2);
    localparam int NW   = $clog2(NOUT);

    result_t       queue [2];
    logic          wr_ptr;
    logic          rd_ptr;
    logic [1:0]    count;
    logic [1:0]    count_nxt;
    logic          wr_req;
    logic          pop;
    logic          active;
    logic          job_go;
    logic [NW-1:0] done_cnt;

    assign pop       = wr_req && i_wr_ack;
    assign count_nxt = count + 2'(i_res_valid) - 2'(pop);
    assign job_go    = i_start && !active;

    assign o_wr_cyc      = wr_req;
    assign o_wr_stb      = wr_req;
    assign o_wr_we       = wr_req;
    assign o_wr_dat      = wb_data_t'(queue[rd_ptr]);
    assign o_queue_empty = (count == 2'd0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_req     <= 1'b0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= '0;
            active     <= 1'b0;
            done_cnt   <= '0;
            o_job_done <= 1'b0;
        end
        else
        begin
            count      <= count_nxt;
            // head of queue stays on the bus until acked
            wr_req     <= (count_nxt != 2'd0);
            o_job_done <= pop && (done_cnt == NW'(NOUT - 1));
            if (i_res_valid)
            begin
                wr_ptr <= !wr_ptr;
            end
            if (pop)
            begin
                rd_ptr   <= !rd_ptr;
                done_cnt <= done_cnt + 1'b1;
            end
            if (job_go)
            begin
                active   <= 1'b1;
                done_cnt <= '0;
            end
            else if (o_job_done)
            begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_res_valid)
        begin
            queue[wr_ptr] <= i_res;
        end
        if (job_go)
        begin
            o_wr_adr <= i_dst_base;
        end
        else if (pop)
        begin
            o_wr_adr <= o_wr_adr + 1'b1;
        end
    end

endmodule

// File: hdl/wb_bus_pkg.sv
package wb_bus_pkg;

    // each address holds one pixel or weight word
    typedef logic [15:0] wb_addr_t;
    typedef logic [15:0] wb_data_t;

endpackage

// File: hdl/window_scanner.sv
`timescale 1ns/1ps

module window_scanner
    import cnn_geom_pkg::*;
#(
    parameter int IMG_DIM = DEF_IMG_DIM
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               i_load_done,
    input  pixel_t                             i_buf_pixel,
    input  logic                               i_queue_empty,
    output logic [$clog2(IMG_DIM*IMG_DIM)-1:0] o_buf_addr,
    output logic                               o_tap_valid,
    output pixel_t                             o_tap_pixel,
    output tap_idx_t                           o_tap_idx,
    output logic                               o_tap_last,
    output logic                               o_tap_pool_last
);

    localparam int LW = $clog2(IMG_DIM);
    localparam int BW = LW - 1;

    logic          running;
    logic          in_block;
    logic [BW-1:0] blk_row;
    logic [BW-1:0] blk_col;
    logic [1:0]    pos;
    logic [1:0]    k_row;
    logic [1:0]    k_col;
    tap_idx_t      tap;
    logic [LW:0]   nb_row;
    logic [LW:0]   nb_col;
    logic          win_last;
    logic          blk_last;
    logic          scan_last;
    logic          pad_d;

    // bit LW set means the neighbour falls outside the image
    assign nb_row = (LW+1)'({blk_row, pos[1]}) + (LW+1)'(k_row) - 1'b1;
    assign nb_col = (LW+1)'({blk_col, pos[0]}) + (LW+1)'(k_col) - 1'b1;

    assign o_buf_addr = {nb_row[LW-1:0], nb_col[LW-1:0]};

    assign win_last  = (k_row == 2'd2) && (k_col == 2'd2);
    assign blk_last  = win_last && (pos == 2'd3);
    assign scan_last = blk_last && (&blk_row) && (&blk_col);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running  <= 1'b0;
            in_block <= 1'b0;
            blk_row  <= '0;
            blk_col  <= '0;
            pos      <= '0;
            k_row    <= '0;
            k_col    <= '0;
            tap      <= '0;
        end
        else if (i_load_done)
        begin
            running <= 1'b1;
            blk_row <= '0;
            blk_col <= '0;
            pos     <= '0;
            k_row   <= '0;
            k_col   <= '0;
            tap     <= '0;
        end
        else if (in_block)
        begin
            // taps in row order, then positions tl, tr, bl, br
            tap   <= win_last ? '0 : tap + 1'b1;
            k_col <= (k_col == 2'd2) ? 2'd0 : k_col + 1'b1;
            if (k_col == 2'd2)
            begin
                k_row <= (k_row == 2'd2) ? 2'd0 : k_row + 1'b1;
            end
            if (win_last)
            begin
                pos <= pos + 1'b1;
            end
            if (blk_last)
            begin
                blk_col <= blk_col + 1'b1;
                if (&blk_col)
                begin
                    blk_row <= blk_row + 1'b1;
                end
                in_block <= !scan_last && i_queue_empty;
                running  <= !scan_last;
            end
        end
        else if (running && i_queue_empty)
        begin
            in_block <= 1'b1;
        end
    end

    // flags follow the buffer's one cycle read latency
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_tap_valid     <= 1'b0;
            o_tap_last      <= 1'b0;
            o_tap_pool_last <= 1'b0;
        end
        else
        begin
            o_tap_valid     <= in_block;
            o_tap_last      <= in_block && win_last;
            o_tap_pool_last <= in_block && blk_last;
        end
    end

    always_ff @(posedge clk)
    begin
        o_tap_idx <= tap;
        pad_d     <= nb_row[LW] || nb_col[LW];
    end

    assign o_tap_pixel = pad_d ? '0 : i_buf_pixel;

endmodule

// File: verification/cnn_pool_sva.sv
`timescale 1ns/1ps

module cnn_pool_sva
    import wb_bus_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     o_rd_cyc,
    input logic     o_rd_stb,
    input wb_addr_t o_rd_adr,
    input logic     i_rd_ack,
    input logic     o_wr_cyc,
    input logic     o_wr_stb,
    input logic     o_wr_we,
    input wb_addr_t o_wr_adr,
    input wb_data_t o_wr_dat,
    input logic     i_wr_ack,
    input logic     o_busy,
    input logic     o_done
);

    a_rd_stb_cyc: assert property (@(posedge clk) disable iff (reset) o_rd_stb |-> o_rd_cyc)
        else $error("read strobe raised without read cycle");

    a_wr_stb_cyc: assert property (@(posedge clk) disable iff (reset) o_wr_stb |-> o_wr_cyc)
        else $error("write strobe raised without write cycle");

    // request held until the slave acks
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        (o_rd_stb && !i_rd_ack) |=> (o_rd_stb && $stable(o_rd_adr)))
        else $error("read request changed before ack");

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        (o_wr_stb && !i_wr_ack) |=> (o_wr_stb && $stable(o_wr_adr) && $stable(o_wr_dat)))
        else $error("write request changed before ack");

    a_wr_we: assert property (@(posedge clk) disable iff (reset) o_wr_stb |-> o_wr_we)
        else $error("write strobe without write enable");

    a_done_busy: assert property (@(posedge clk) disable iff (reset) o_done |-> o_busy)
        else $error("done pulse outside a busy job");

endmodule

bind cnn_pool cnn_pool_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .o_rd_cyc (o_rd_cyc),
    .o_rd_stb (o_rd_stb),
    .o_rd_adr (o_rd_adr),
    .i_rd_ack (i_rd_ack),
    .o_wr_cyc (o_wr_cyc),
    .o_wr_stb (o_wr_stb),
    .o_wr_we  (o_wr_we),
    .o_wr_adr (o_wr_adr),
    .o_wr_dat (o_wr_dat),
    .i_wr_ack (i_wr_ack),
    .o_busy   (o_busy),
    .o_done   (o_done)
);

// File: verification/tb_cnn_pool.sv
`timescale 1ns/1ps

module tb_cnn_pool
    import cnn_geom_pkg::*, wb_bus_pkg::*;
;

    localparam int DIM   = 8;
    localparam int NOUT  = (DIM / 2) * (DIM / 2);
    localparam int NREAD = KERNEL_TAPS + DIM * DIM;
    localparam int LIMIT = 20000;

    logic     clk = 1'b0;
    logic     reset;
    logic     i_start;
    wb_addr_t i_src_base;
    wb_addr_t i_dst_base;
    wb_data_t i_rd_dat;
    logic     i_rd_ack;
    logic     i_wr_ack;
    logic     o_rd_cyc;
    logic     o_rd_stb;
    wb_addr_t o_rd_adr;
    logic     o_wr_cyc;
    logic     o_wr_stb;
    logic     o_wr_we;
    wb_addr_t o_wr_adr;
    wb_data_t o_wr_dat;
    logic     o_busy;
    logic     o_done;

    wb_data_t    mem [65536];
    wb_data_t    wr_dat_log [NOUT];
    result_t     exp_res [NOUT];
    int          kern [KERNEL_TAPS];
    logic [15:0] lfsr = 16'd5932;
    wb_addr_t    job_src;
    wb_addr_t    job_dst;
    int          rd_count;
    int          wr_count;
    int          done_count;
    int          rd_wait;
    int          wr_wait;
    int          wr_bits;
    logic [31:0] rd_draw;
    logic [31:0] wr_draw;

    cnn_pool #(.IMG_DIM(DIM)) i_cnn_pool (
        .clk        (clk),
        .reset      (reset),
        .i_start    (i_start),
        .i_src_base (i_src_base),
        .i_dst_base (i_dst_base),
        .i_rd_dat   (i_rd_dat),
        .i_rd_ack   (i_rd_ack),
        .i_wr_ack   (i_wr_ack),
        .o_rd_cyc   (o_rd_cyc),
        .o_rd_stb   (o_rd_stb),
        .o_rd_adr   (o_rd_adr),
        .o_wr_cyc   (o_wr_cyc),
        .o_wr_stb   (o_wr_stb),
        .o_wr_we    (o_wr_we),
        .o_wr_adr   (o_wr_adr),
        .o_wr_dat   (o_wr_dat),
        .o_busy     (o_busy),
        .o_done     (o_done)
    );

    always #5 clk = ~clk;

    task fail_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task check_result(input string name, input result_t act, input result_t exp);
        if (act !== exp)
            fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, exp));
    endtask

    task check_addr(input string name, input wb_addr_t act, input wb_addr_t exp);
        if (act !== exp)
            fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, exp));
    endtask

    task check_flag(input string name, input logic act, input logic exp);
        if (act !== exp)
            fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, exp));
    endtask

    // Fibonacci taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] random_bits(input int n);
        logic        fb;
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic int pixel_at(input wb_addr_t src, input int r, input int c);
        if (r < 0 || r >= DIM || c < 0 || c >= DIM)
            return 0;
        return int'(mem[src + wb_addr_t'(KERNEL_TAPS + r * DIM + c)][7:0]);
    endfunction

    // convolution, ReLU, 2x2 max and clip of every block
    task compute_reference(input wb_addr_t src);
        int w [KERNEL_TAPS];
        int best;
        int acc;
        int r;
        int c;
        for (int k = 0; k < KERNEL_TAPS; k++)
            w[k] = int'($signed(mem[src + wb_addr_t'(k)][7:0]));
        for (int b = 0; b < NOUT; b++)
        begin
            best = 0;
            for (int p = 0; p < 4; p++)
            begin
                r   = 2 * (b / (DIM / 2)) + p / 2;
                c   = 2 * (b % (DIM / 2)) + p % 2;
                acc = 0;
                for (int k = 0; k < KERNEL_TAPS; k++)
                    acc += w[k] * pixel_at(src, r + k / 3 - 1, c + k % 3 - 1);
                if (acc > best)
                    best = acc;
            end
            if (best > 65535)
                best = 65535;
            exp_res[b] = result_t'(best);
        end
    endtask

    task store_kernel(input wb_addr_t src);
        logic [31:0] noise;
        for (int k = 0; k < KERNEL_TAPS; k++)
        begin
            noise = random_bits(8);
            mem[src + wb_addr_t'(k)] = {noise[7:0], 8'(kern[k])};
        end
    endtask

    task fill_random(input wb_addr_t src);
        logic [31:0] draw;
        for (int k = 0; k < KERNEL_TAPS; k++)
        begin
            draw    = random_bits(8);
            kern[k] = int'($signed(draw[7:0]));
        end
        store_kernel(src);
        for (int i = 0; i < DIM * DIM; i++)
        begin
            draw = random_bits(16);
            mem[src + wb_addr_t'(KERNEL_TAPS + i)] = draw[15:0];
        end
    endtask

    // read slave acks after 0 to 3 wait cycles
    always @(posedge clk)
    begin
        #1;
        if (reset)
        begin
            i_rd_ack = 1'b0;
            rd_wait  = -1;
        end
        else if (i_rd_ack)
            i_rd_ack = 1'b0;
        else if (o_rd_stb)
        begin
            if (rd_wait < 0)
            begin
                rd_draw = random_bits(2);
                rd_wait = int'(rd_draw);
            end
            if (rd_wait == 0)
            begin
                if (rd_count >= NREAD)
                    fail_run("read master issued more reads than one job needs");
                check_addr("o_rd_adr", o_rd_adr, job_src + wb_addr_t'(rd_count));
                i_rd_dat = mem[o_rd_adr];
                i_rd_ack = 1'b1;
                rd_count++;
                rd_wait  = -1;
            end
            else
                rd_wait--;
        end
    end

    // write slave wait range follows wr_bits
    always @(posedge clk)
    begin
        #1;
        if (reset)
        begin
            i_wr_ack = 1'b0;
            wr_wait  = -1;
        end
        else if (i_wr_ack)
            i_wr_ack = 1'b0;
        else if (o_wr_stb)
        begin
            if (wr_wait < 0)
            begin
                wr_draw = random_bits(wr_bits);
                wr_wait = int'(wr_draw);
            end
            if (wr_wait == 0)
            begin
                if (wr_count >= NOUT)
                    fail_run("write master issued more writes than one job needs");
                check_flag("o_wr_we", o_wr_we, 1'b1);
                check_addr("o_wr_adr", o_wr_adr, job_dst + wb_addr_t'(wr_count));
                wr_dat_log[wr_count] = o_wr_dat;
                i_wr_ack = 1'b1;
                wr_count++;
                wr_wait  = -1;
            end
            else
                wr_wait--;
        end
    end

    always @(posedge clk)
    begin
        #1;
        if (!reset && o_done)
        begin
            check_flag("all writes acked before o_done", wr_count == NOUT, 1'b1);
            done_count++;
        end
    end

    task start_job(input wb_addr_t src, input wb_addr_t dst);
        @(posedge clk);
        #1;
        job_src    = src;
        job_dst    = dst;
        rd_count   = 0;
        wr_count   = 0;
        done_count = 0;
        i_src_base = src;
        i_dst_base = dst;
        i_start    = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
    endtask

    task wait_done();
        int cycles;
        cycles = 0;
        while (done_count == 0)
        begin
            if (cycles == LIMIT)
                fail_run("timed out waiting for o_done");
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    task wait_reads(input int n);
        int cycles;
        cycles = 0;
        while (rd_count < n)
        begin
            if (cycles == LIMIT)
                fail_run("timed out waiting for image reads");
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    // short quiet window catches late writes or a second done
    task verify_job();
        repeat (20) @(posedge clk);
        #2;
        check_flag("o_busy", o_busy, 1'b0);
        check_flag("single o_done pulse", done_count == 1, 1'b1);
        check_flag("read count complete", rd_count == NREAD, 1'b1);
        check_flag("write count complete", wr_count == NOUT, 1'b1);
        for (int i = 0; i < NOUT; i++)
            check_result($sformatf("o_wr_dat[%0d]", i), result_t'(wr_dat_log[i]), exp_res[i]);
    endtask

    task test_reset_idle();
        @(posedge clk);
        #2;
        check_flag("o_rd_cyc", o_rd_cyc, 1'b0);
        check_flag("o_rd_stb", o_rd_stb, 1'b0);
        check_flag("o_wr_cyc", o_wr_cyc, 1'b0);
        check_flag("o_wr_stb", o_wr_stb, 1'b0);
        check_flag("o_busy", o_busy, 1'b0);
        check_flag("o_done", o_done, 1'b0);
    endtask

    task test_identity();
        wb_addr_t src;
        wb_addr_t a;
        int       best;
        int       px;
        src = 16'h0100;
        for (int k = 0; k < KERNEL_TAPS; k++)
            kern[k] = (k == 4) ? 1 : 0;
        store_kernel(src);
        for (int i = 0; i < DIM * DIM; i++)
        begin
            a = src + wb_addr_t'(KERNEL_TAPS + i);
            mem[a] = {a[7:0] ^ a[15:8], 8'(a[7:0] * 8'd37) ^ a[15:8]};
        end
        // centre tap only, so each result is the block's largest pixel
        for (int b = 0; b < NOUT; b++)
        begin
            best = 0;
            for (int p = 0; p < 4; p++)
            begin
                px = pixel_at(src, 2 * (b / (DIM / 2)) + p / 2, 2 * (b % (DIM / 2)) + p % 2);
                if (px > best)
                    best = px;
            end
            exp_res[b] = result_t'(best);
        end
        start_job(src, 16'h0800);
        wait_done();
        verify_job();
    endtask

    task test_random();
        fill_random(16'h1230);
        compute_reference(16'h1230);
        start_job(16'h1230, 16'h2000);
        wait_done();
        verify_job();
    endtask

    task test_border_clip();
        wb_addr_t a;
        for (int k = 0; k < KERNEL_TAPS; k++)
            kern[k] = 127;
        store_kernel(16'h3000);
        for (int i = 0; i < DIM * DIM; i++)
        begin
            a = 16'h3000 + wb_addr_t'(KERNEL_TAPS + i);
            mem[a] = {a[7:0] ^ a[15:8], 8'hff};
        end
        compute_reference(16'h3000);
        start_job(16'h3000, 16'h3800);
        wait_done();
        verify_job();
    endtask

    task test_backpressure();
        wr_bits = 4;
        fill_random(16'h4000);
        compute_reference(16'h4000);
        start_job(16'h4000, 16'h5000);
        wait_reads(20);
        check_flag("o_busy", o_busy, 1'b1);
        // second start with another base must leave the job untouched
        @(posedge clk);
        #1;
        i_src_base = 16'h6000;
        i_dst_base = 16'h7000;
        i_start    = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
        wait_done();
        verify_job();
        wr_bits = 2;
    endtask

    initial
    begin
        reset      = 1'b1;
        i_start    = 1'b0;
        i_src_base = '0;
        i_dst_base = '0;
        i_rd_dat   = '0;
        i_rd_ack   = 1'b0;
        i_wr_ack   = 1'b0;
        rd_count   = 0;
        wr_count   = 0;
        done_count = 0;
        wr_bits    = 2;
        job_src    = '0;
        job_dst    = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_idle();
        test_identity();
        test_random();
        test_border_clip();
        test_backpressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule
